/* tdc_readout_top.f */
logic/tdc_readout_pkg.sv
logic/acq_control.sv
logic/fifo_stage.sv
logic/uart_tx.sv
logic/uart_readout.sv
logic/tdc_readout_top.sv
testbench/tdc_readout_tb.sv

/* testbench/tdc_readout_tb.sv */
// testbench: random tdc words, queue model, uart decoder and checks for the readout top
`timescale 1ns/100ps
`default_nettype none

module tdc_readout_tb
    import tdc_readout_pkg::*;
();

    localparam int FIFO_STAGES     = 4;
    localparam int STAGE_DEPTH     = 8;
    localparam int CLKS_PER_BIT    = 8;
    localparam int READ_LIMIT      = 16;
    localparam int CAPACITY        = FIFO_STAGES * STAGE_DEPTH;
    localparam int RESET_CYCLES    = 10;
    localparam int STROBE_GAP      = 6;
    localparam int N_IDLE_STROBES  = 3;
    localparam int N_WRITE_STROBES = 40;
    localparam int N_SHORT_RUN     = 5;
    localparam int FRAME_CYCLES    = UART_FRAME_BITS * CLKS_PER_BIT;
    localparam int IDLE_CYCLES     = 5 * FRAME_CYCLES;
    // both runs: resets, strobes and the idle windows
    localparam int WRITE_PHASE     = 2 * (RESET_CYCLES + IDLE_CYCLES + 20 +
                                          (N_IDLE_STROBES + N_WRITE_STROBES) * STROBE_GAP);
    localparam int READ_PHASE      = READ_LIMIT * BYTES_PER_WORD * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES  = 2 * (WRITE_PHASE + READ_PHASE);

    logic      clkWizard = 1'b0;
    logic      finish_mem_reset;
    logic      measure_done;
    tdc_word_u measure_word;
    logic      start_writing;
    logic      start_reading;
    logic      led_write_err;
    logic      led_write_stage;
    logic      led_read_stage;
    logic      tx;

    // model state
    tdc_word_u          model_words [$];
    logic [NB_BYTE-1:0] exp_bytes [$];
    logic [31:0]        rng_state      = 32'd59292;
    int                 rx_bytes       = 0;
    int                 err_pulses     = 0;
    int                 exp_err_pulses = 0;
    int                 err_base       = 0;
    int                 error_count    = 0;
    int                 cycle_count    = 0;

    always #5 clkWizard = ~clkWizard;

    tdc_readout_top #(
        .FIFO_STAGES  (FIFO_STAGES),
        .STAGE_DEPTH  (STAGE_DEPTH),
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .READ_LIMIT   (READ_LIMIT)
    ) DUT (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .measure_done     (measure_done),
        .measure_word     (measure_word),
        .start_writing    (start_writing),
        .start_reading    (start_reading),
        .led_write_err    (led_write_err),
        .led_write_stage  (led_write_stage),
        .led_read_stage   (led_read_stage),
        .tx               (tx)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // coarse and fine from two separate draws
    function automatic tdc_word_u random_word();
        tdc_word_u w;
        rng_state = xorshift32(rng_state);
        w.meas.coarse_count = rng_state[NB_COARSE-1:0];
        rng_state = xorshift32(rng_state);
        w.meas.fine_code = rng_state[NB_FINE-1:0];
        return w;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR: %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clkWizard);
        #1;
    endtask

    task automatic apply_reset();
        finish_mem_reset = 1'b1;
        repeat (RESET_CYCLES) tick();
        finish_mem_reset = 1'b0;
    endtask

    task automatic press_buttons(input bit wr, input bit rd);
        start_writing = wr;
        start_reading = rd;
        tick();
        start_writing = 1'b0;
        start_reading = 1'b0;
    endtask

    task automatic check_leds(input bit wr_stage, input bit rd_stage);
        assert (led_write_stage === wr_stage && led_read_stage === rd_stage)
            else report_error($sformatf("stage leds write=%b read=%b, expected %b %b",
                                        led_write_stage, led_read_stage, wr_stage, rd_stage));
    endtask

    // one done strobe, model follows the push rule
    task automatic send_strobe(input bit in_writing);
        tdc_word_u w;
        bit        accept;
        bit        expect_err;
        w = random_word();
        // gap lets words settle, so stage 0 is full only with the whole chain full
        accept     = in_writing && (model_words.size() < CAPACITY);
        expect_err = in_writing && !accept;
        measure_word = w;
        measure_done = 1'b1;
        tick();
        measure_done = 1'b0;
        if (accept) begin
            model_words.push_back(w);
        end
        if (expect_err) begin
            exp_err_pulses++;
        end
        assert (led_write_err === expect_err)
            else report_error($sformatf("led_write_err is %b after strobe, expected %b",
                                        led_write_err, expect_err));
        tick();
        assert (led_write_err === 1'b0)
            else report_error("led_write_err is high for more than one cycle");
        repeat (STROBE_GAP - 2) tick();
    endtask

    // bytes of the first words up to the limit, low byte first
    task automatic load_expected_bytes();
        logic [NB_WORD-1:0] bits;
        int                 n_words;
        n_words = (model_words.size() < READ_LIMIT) ? model_words.size() : READ_LIMIT;
        exp_bytes.delete();
        for (int i = 0; i < n_words; i++) begin
            bits = model_words[i];
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                exp_bytes.push_back(bits[NB_BYTE*b +: NB_BYTE]);
            end
        end
    endtask

    task automatic wait_for_bytes(input int n);
        while (rx_bytes < n) begin
            tick();
        end
    endtask

    // line must stay idle, no byte may appear
    task automatic check_line_idle(input int n_cycles);
        int seen;
        seen = rx_bytes;
        repeat (n_cycles) begin
            @(negedge clkWizard);
            assert (tx === 1'b1) else report_error("tx left idle when no word was due");
        end
        assert (rx_bytes == seen)
            else report_error($sformatf("%0d extra bytes on the line", rx_bytes - seen));
    endtask

    // ------------------------------------------------------------
    // uart decoder, samples mid-bit on falling clock edges
    // ------------------------------------------------------------
    task automatic receive_frame();
        logic [NB_BYTE-1:0] data;
        logic [NB_BYTE-1:0] expected;
        repeat (CLKS_PER_BIT / 2) @(negedge clkWizard);
        assert (tx === 1'b0) else report_error("start bit shorter than half a bit");
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clkWizard);
            data[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clkWizard);
        assert (tx === 1'b1) else report_error("stop bit missing");
        assert (exp_bytes.size() > 0) else report_error("byte sent with no word due");
        expected = exp_bytes.pop_front();
        assert (data === expected)
            else report_error($sformatf("byte %0d is 0x%02h, expected 0x%02h",
                                        rx_bytes, data, expected));
        rx_bytes++;
    endtask

    initial begin : uart_decoder
        forever begin
            @(negedge tx);
            receive_frame();
        end
    end

    // one count per cycle of the error led
    always @(negedge clkWizard) begin
        if (led_write_err === 1'b1) begin
            err_pulses <= err_pulses + 1;
        end
    end

    always @(posedge clkWizard) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        finish_mem_reset = 1'b1;
        measure_done     = 1'b0;
        measure_word     = '0;
        start_writing    = 1'b0;
        start_reading    = 1'b0;
        apply_reset();

        // waiting state, strobes are ignored
        assert (tx === 1'b1 && led_write_err === 1'b0) else report_error("bad reset outputs");
        check_leds(1'b0, 1'b0);
        repeat (N_IDLE_STROBES) send_strobe(1'b0);

        // writing, chain fills then overflows
        press_buttons(1'b1, 1'b0);
        repeat (2) tick();
        check_leds(1'b1, 1'b0);
        err_base = err_pulses;
        repeat (N_WRITE_STROBES) send_strobe(1'b1);
        assert (err_pulses - err_base == exp_err_pulses &&
                exp_err_pulses == N_WRITE_STROBES - CAPACITY)
            else report_error($sformatf("%0d write error pulses, expected %0d",
                                        err_pulses - err_base, N_WRITE_STROBES - CAPACITY));

        // reading up to the limit
        load_expected_bytes();
        press_buttons(1'b0, 1'b1);
        repeat (2) tick();
        check_leds(1'b0, 1'b1);
        wait_for_bytes(READ_LIMIT * BYTES_PER_WORD);
        check_line_idle(IDLE_CYCLES);
        assert (exp_bytes.size() == 0) else report_error("bytes missing after the read limit");

        // short run after a fresh reset
        apply_reset();
        model_words.delete();
        rx_bytes       = 0;
        exp_err_pulses = 0;
        err_base       = err_pulses;
        check_leds(1'b0, 1'b0);
        press_buttons(1'b1, 1'b0);
        repeat (2) tick();
        repeat (N_SHORT_RUN) send_strobe(1'b1);
        load_expected_bytes();
        press_buttons(1'b0, 1'b1);
        wait_for_bytes(N_SHORT_RUN * BYTES_PER_WORD);

        // reading is final, buttons and strobes do nothing
        press_buttons(1'b1, 1'b0);
        press_buttons(1'b0, 1'b1);
        send_strobe(1'b0);
        check_leds(1'b0, 1'b1);
        check_line_idle(IDLE_CYCLES);
        assert (exp_bytes.size() == 0 && err_pulses == err_base)
            else report_error("short run left bytes unsent or raised a write error");

        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* logic/tdc_readout_top.sv */
// readout top: acquisition control, chain of FIFO stages, uart readout
`timescale 1ns/100ps
`default_nettype none

module tdc_readout_top
    import tdc_readout_pkg::*;
#(
    parameter int FIFO_STAGES  = 4,
    parameter int STAGE_DEPTH  = 8,
    parameter int CLKS_PER_BIT = 64,
    parameter int READ_LIMIT   = 1024
) (
    input  wire            clkWizard,
    input  wire            finish_mem_reset,
    input  wire            measure_done,
    input  wire tdc_word_u measure_word,
    input  wire            start_writing,
    input  wire            start_reading,
    output logic           led_write_err,
    output logic           led_write_stage,
    output logic           led_read_stage,
    output logic           tx
);

    // boundary k feeds stage k
    // index 0 is the acq push
    // last index faces the readout
    wire            chain_valid [0:FIFO_STAGES];
    wire tdc_word_u chain_word  [0:FIFO_STAGES];
    wire            chain_take  [0:FIFO_STAGES];
    wire            full        [0:FIFO_STAGES-1];
    wire            read_enable;

    acq_control u_acq_control (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .measure_done     (measure_done),
        .measure_word     (measure_word),
        .start_writing    (start_writing),
        .start_reading    (start_reading),
        .stage_full       (full[0]),
        .push             (chain_valid[0]),
        .push_word        (chain_word[0]),
        .read_enable      (read_enable),
        .led_write_err    (led_write_err),
        .led_write_stage  (led_write_stage),
        .led_read_stage   (led_read_stage)
    );

    // ------------------------------------------------------------
    // fifo chain
    // ------------------------------------------------------------
    for (genvar k = 0; k < FIFO_STAGES; k++) begin : g_stage
        fifo_stage #(
            .STAGE_DEPTH (STAGE_DEPTH)
        ) u_fifo_stage (
            .clkWizard        (clkWizard),
            .finish_mem_reset (finish_mem_reset),
            .up_valid         (chain_valid[k]),
            .up_word          (chain_word[k]),
            .up_take          (chain_take[k]),
            .head_valid       (chain_valid[k+1]),
            .head_word        (chain_word[k+1]),
            .take             (chain_take[k+1]),
            .full             (full[k])
        );
    end

    // drain side
    uart_readout #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .READ_LIMIT   (READ_LIMIT)
    ) u_uart_readout (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .read_enable      (read_enable),
        .head_valid       (chain_valid[FIFO_STAGES]),
        .head_word        (chain_word[FIFO_STAGES]),
        .take             (chain_take[FIFO_STAGES]),
        .tx               (tx)
    );

endmodule

`default_nettype wire

/* logic/uart_readout.sv */
// chain drain: takes head words, steps through their bytes, enforces the read limit
`timescale 1ns/100ps
`default_nettype none

module uart_readout
    import tdc_readout_pkg::*;
#(
    parameter int CLKS_PER_BIT = 64,
    parameter int READ_LIMIT   = 1024
) (
    input  wire            clkWizard,
    input  wire            finish_mem_reset,
    input  wire            read_enable,
    // last chain stage
    input  wire            head_valid,
    input  wire tdc_word_u head_word,
    output logic           take,
    // serial line
    output logic           tx
);

    localparam int CNT_W = $clog2(READ_LIMIT + 1);
    localparam int IDX_W = $clog2(BYTES_PER_WORD);

    localparam logic [CNT_W-1:0] LIMIT_CNT = CNT_W'(READ_LIMIT);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(BYTES_PER_WORD - 1);

    // current word, payload only
    tdc_word_u word_reg;

    logic              holding;
    logic [IDX_W-1:0]  byte_idx;
    logic [CNT_W-1:0]  words_sent;

    // transmitter handshake
    logic send;
    logic busy;
    byte  tx_byte;

    // ------------------------------------------------------------
    // word fetch
    // ------------------------------------------------------------
    // never pulls an empty chain, stops at the limit
    assign take = read_enable && head_valid && !holding && (words_sent < LIMIT_CNT);

    always_ff @(posedge clkWizard) begin
        if (take) begin
            word_reg <= head_word;
        end
    end

    // byte view, low byte first
    assign tx_byte = word_reg.bytes[byte_idx];

    // ------------------------------------------------------------
    // byte sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            holding    <= 1'b0;
            byte_idx   <= '0;
            words_sent <= '0;
            send       <= 1'b0;
        end else begin
            // one-cycle strobe once the line is free
            // busy lags send by a cycle, hence the !send term
            send <= holding && !busy && !send;

            if (take) begin
                holding    <= 1'b1;
                byte_idx   <= '0;
                words_sent <= words_sent + 1'b1;
            end else if (send) begin
                // byte handed over on this edge
                if (byte_idx == IDX_LAST) begin
                    holding  <= 1'b0;
                    byte_idx <= '0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .send             (send),
        .tx_byte          (tx_byte),
        .busy             (busy),
        .tx               (tx)
    );

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
// 8N1 serial transmitter with its own baud tick counter
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import tdc_readout_pkg::*;
#(
    parameter int CLKS_PER_BIT = 64
) (
    input  wire     clkWizard,
    input  wire     finish_mem_reset,
    input  wire     send,
    input  var byte tx_byte,
    output logic    busy,
    output logic    tx
);

    localparam int TICK_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W  = $clog2(UART_FRAME_BITS);

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(UART_FRAME_BITS - 1);

    // baud divider and bit position in the frame
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_idx;
    logic              bit_end;

    // data bits then the stop bit, shifted out lsb first
    logic [UART_DATA_BITS:0] shreg;

    assign bit_end = (tick_cnt == TICK_LAST);

    // ------------------------------------------------------------
    // payload shifter
    // ------------------------------------------------------------
    always_ff @(posedge clkWizard) begin
        if (send && !busy) begin
            // stop bit rides on top
            shreg <= {1'b1, tx_byte};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[UART_DATA_BITS:1]};
        end
    end

    // ------------------------------------------------------------
    // line control
    // ------------------------------------------------------------
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            busy     <= 1'b0;
            tx       <= 1'b1;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            if (send) begin
                // start bit goes out right away
                busy <= 1'b1;
                tx   <= 1'b0;
            end
        end else if (bit_end) begin
            tick_cnt <= '0;
            if (bit_idx == BIT_LAST) begin
                // stop bit done, back to idle
                busy <= 1'b0;
                tx   <= 1'b1;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                tx      <= shreg[0];
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // the readout must hold off while a frame is on the line
    a_no_send_while_busy : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        send |-> !busy
    );

endmodule

`default_nettype wire

/* logic/fifo_stage.sv */
// one register-file FIFO stage that pulls words from its upstream neighbour
`timescale 1ns/100ps
`default_nettype none

module fifo_stage
    import tdc_readout_pkg::*;
#(
    parameter int STAGE_DEPTH = 8
) (
    input  wire            clkWizard,
    input  wire            finish_mem_reset,
    // upstream neighbour (or the acq push for stage 0)
    input  wire            up_valid,
    input  wire tdc_word_u up_word,
    output logic           up_take,
    // downstream view of our oldest word
    output logic           head_valid,
    output tdc_word_u      head_word,
    input  wire            take,
    output logic           full
);

    localparam int         AW        = $clog2(STAGE_DEPTH);
    localparam logic [AW:0] DEPTH_CNT = (AW + 1)'(STAGE_DEPTH);

    // storage, no reset on the payload
    tdc_word_u mem [STAGE_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [AW:0]   count;

    // ------------------------------------------------------------
    // flags and handshake
    // ------------------------------------------------------------
    assign full       = (count == DEPTH_CNT);
    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];

    // we decide the pull ourselves, upstream pops blindly
    assign up_take = up_valid && !full;

    always_ff @(posedge clkWizard) begin
        if (up_take) begin
            mem[wr_ptr] <= up_word;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (up_take) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({up_take, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // downstream pulls only a valid head
    a_take_needs_head : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        take |-> head_valid
    );

    // occupancy bound
    a_count_bound : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        count <= DEPTH_CNT
    );

endmodule

`default_nettype wire

/* logic/acq_control.sv */
// acquisition FSM: waiting/writing/reading, push gating, write error and stage LEDs
`timescale 1ns/100ps
`default_nettype none

module acq_control
    import tdc_readout_pkg::*;
(
    input  wire            clkWizard,
    input  wire            finish_mem_reset,
    // converter side
    input  wire            measure_done,
    input  wire tdc_word_u measure_word,
    // buttons, plain levels
    input  wire            start_writing,
    input  wire            start_reading,
    // chain entry
    input  wire            stage_full,
    output logic           push,
    output tdc_word_u      push_word,
    // readout side
    output logic           read_enable,
    // board leds
    output logic           led_write_err,
    output logic           led_write_stage,
    output logic           led_read_stage
);

    // ------------------------------------------------------------
    // state codes
    // ------------------------------------------------------------
    localparam logic [1:0] ST_WAITING = 2'd0;
    localparam logic [1:0] ST_WRITING = 2'd1;
    localparam logic [1:0] ST_READING = 2'd2;

    logic [1:0] state;
    logic       writing;

    assign writing = (state == ST_WRITING);

    // state register
    // write button wins over read button while waiting
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            state <= ST_WAITING;
        end else begin
            case (state)
                ST_WAITING: begin
                    if (start_writing) begin
                        state <= ST_WRITING;
                    end else if (start_reading) begin
                        state <= ST_READING;
                    end
                end
                ST_WRITING: begin
                    if (start_reading) begin
                        state <= ST_READING;
                    end
                end
                // reading holds until reset
                ST_READING: state <= ST_READING;
                default:    state <= ST_WAITING;
            endcase
        end
    end

    // ------------------------------------------------------------
    // chain entry
    // ------------------------------------------------------------
    // strobe passes only while writing and stage 0 has room
    assign push = measure_done && writing && !stage_full;

    // word goes in field by field from the measurement view
    always_comb begin
        push_word.meas.coarse_count = measure_word.meas.coarse_count;
        push_word.meas.fine_code    = measure_word.meas.fine_code;
    end

    assign read_enable = (state == ST_READING);

    // dropped strobe flag, one cycle wide
    // stage leds trail the state register by one cycle
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            led_write_err   <= 1'b0;
            led_write_stage <= 1'b0;
            led_read_stage  <= 1'b0;
        end else begin
            led_write_err   <= measure_done && writing && stage_full;
            led_write_stage <= writing;
            led_read_stage  <= (state == ST_READING);
        end
    end

    // stage 0 must never see a push while it reports full
    a_no_push_when_full : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        !(push && stage_full)
    );

endmodule

`default_nettype wire

/* logic/tdc_readout_pkg.sv */
// word widths, uart frame constants and the tdc measurement word union
`default_nettype none

package tdc_readout_pkg;

    // ------------------------------------------------------------
    // word geometry
    // ------------------------------------------------------------
    localparam int NB_BYTE        = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int NB_WORD        = NB_BYTE * BYTES_PER_WORD;

    // converter fields, coarse on top
    localparam int NB_FINE   = 12;
    localparam int NB_COARSE = NB_WORD - NB_FINE;

    // ------------------------------------------------------------
    // uart frame, 8N1
    // ------------------------------------------------------------
    localparam int UART_DATA_BITS  = 8;
    // start + data + stop
    localparam int UART_FRAME_BITS = UART_DATA_BITS + 2;

    // measurement view of a fifo word
    typedef struct packed {
        logic [NB_COARSE-1:0] coarse_count;
        logic [NB_FINE-1:0]   fine_code;
    } tdc_meas_t;

    // one fifo word, seen as a measurement or as uart bytes
    // bytes[0] is bits 7..0, the first byte on the line
    typedef union packed {
        tdc_meas_t                              meas;
        logic [BYTES_PER_WORD-1:0][NB_BYTE-1:0] bytes;
    } tdc_word_u;

endpackage

`default_nettype wire
